/* build.f */
glb_param_pkg.sv
glb_cfg_pkg.sv
glb_bank.sv
glb_store_dma.sv
glb_cfg_node.sv
glb_tile.sv
glb_top.sv
glb_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module glb_tb -o glb_sim
sim_out=$(./obj_dir/glb_sim)
echo "$sim_out"
grep -q "All tests passed" <<< "$sim_out"

/* glb_tb.sv */
// directed testbench for the global buffer chain
// reads wait for cfg_rd_data_valid, interrupt bits are counted per cycle high
// bank words are only read back where a test stored them
module glb_tb
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RD_TIMEOUT   = 200;
    localparam int IRQ_TIMEOUT  = 100;
    localparam int NUM_HDR_REGS = 2 * QUEUE_DEPTH;

    logic       clk;
    logic       reset;
    logic       cfg_wr_en;
    cfg_addr_t  cfg_wr_addr;
    cfg_data_t  cfg_wr_data;
    logic       cfg_rd_en;
    cfg_addr_t  cfg_rd_addr;
    cfg_data_t  cfg_rd_data;
    logic       cfg_rd_data_valid;
    data_word_t stream_data;
    logic       stream_valid;
    irq_vec_t   interrupt_pulse;

    int         errors;
    int         checks;
    int         timeouts;
    int         irq_seen [NUM_TILES];
    data_word_t sent [$];

    glb_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // high cycles per interrupt bit, sampled like a flop
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int b = 0; b < NUM_TILES; b++) begin
                irq_seen[b] <= 0;
            end
        end else begin
            for (int b = 0; b < NUM_TILES; b++) begin
                if (interrupt_pulse[b]) begin
                    irq_seen[b] <= irq_seen[b] + 1;
                end
            end
        end
    end

    // tile in [15:12], bank select in bit 11
    function automatic cfg_addr_t reg_addr(input int tile, input int idx);
        return cfg_addr_t'((tile << 12) | (idx & 'h1f));
    endfunction

    function automatic cfg_addr_t bank_addr(input int tile, input int word);
        return cfg_addr_t'((tile << 12) | (1 << 11) | (word & 'hff));
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at time %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
        @(negedge clk);
        cfg_wr_en   = 1'b1;
        cfg_wr_addr = addr;
        cfg_wr_data = data;
        @(negedge clk);
        cfg_wr_en = 1'b0;
    endtask

    task automatic cfg_read(input cfg_addr_t addr, output cfg_data_t data);
        bit seen;
        seen = 1'b0;
        data = '0;
        @(negedge clk);
        cfg_rd_en   = 1'b1;
        cfg_rd_addr = addr;
        // valid may already be up one cycle after the strobe
        for (int cyc = 0; cyc < RD_TIMEOUT && !seen; cyc++) begin
            @(negedge clk);
            cfg_rd_en = 1'b0;
            if (cfg_rd_data_valid) begin
                data = cfg_rd_data;
                seen = 1'b1;
            end
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: no read response for address 0x%04h within %0d cycles",
                     addr, RD_TIMEOUT);
        end
    endtask

    task automatic expect_read(input cfg_addr_t addr, input cfg_data_t exp, input string what);
        cfg_data_t got;
        cfg_read(addr, got);
        check_equal(32'(got), 32'(exp), what);
    endtask

    // n back-to-back random words, kept in sent
    task automatic stream_words(input int n);
        sent.delete();
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            stream_valid = 1'b1;
            stream_data  = data_word_t'($urandom);
            sent.push_back(stream_data);
        end
        @(negedge clk);
        stream_valid = 1'b0;
    endtask

    task automatic wait_irq(input int tile, input int target);
        int cyc;
        cyc = 0;
        while (irq_seen[tile] < target && cyc < IRQ_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (irq_seen[tile] < target) begin
            timeouts++;
            $display("timeout: tile %0d raised %0d interrupts, %0d expected",
                     tile, irq_seen[tile], target);
        end
    endtask

    task automatic check_irq_counts(input int base [NUM_TILES], input int tile, input int n);
        for (int b = 0; b < NUM_TILES; b++) begin
            check_equal(irq_seen[b], base[b] + ((b == tile) ? n : 0),
                        $sformatf("interrupt bit %0d pulse count", b));
        end
    endtask

    // reset values, then header fields read back masked to 9 bits
    task automatic test_registers();
        cfg_data_t val;
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int idx = 0; idx <= NUM_HDR_REGS; idx++) begin
                expect_read(reg_addr(t, idx), '0, $sformatf("reset tile %0d reg %0d", t, idx));
            end
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int idx = 1; idx <= NUM_HDR_REGS; idx++) begin
                val = cfg_data_t'($urandom);
                cfg_write(reg_addr(t, idx), val);
                expect_read(reg_addr(t, idx), val & 16'h01ff,
                            $sformatf("readback tile %0d reg %0d", t, idx));
            end
            // unmapped index keeps reading zero
            cfg_write(reg_addr(t, 20), 16'hffff);
            expect_read(reg_addr(t, 20), '0, $sformatf("unmapped reg tile %0d", t));
            for (int idx = 1; idx <= NUM_HDR_REGS; idx++) begin
                cfg_write(reg_addr(t, idx), '0);
            end
        end
    endtask

    task automatic test_isolation();
        int        target;
        cfg_data_t val;
        target = $urandom_range(NUM_TILES - 1, 0);
        val    = cfg_data_t'($urandom_range(511, 1));
        // num_words of header 0
        cfg_write(reg_addr(target, 2), val);
        for (int t = 0; t < NUM_TILES; t++) begin
            expect_read(reg_addr(t, 2), (t == target) ? val : '0,
                        $sformatf("isolation tile %0d, write to tile %0d", t, target));
        end
        cfg_write(reg_addr(target, 2), '0);
    endtask

    // one header, stream, bank readback, single done pulse
    task automatic test_store(input int tile);
        int start;
        int n;
        int base [NUM_TILES];
        start = $urandom_range(255, 0);
        n     = $urandom_range(12, 4);
        base  = irq_seen;
        cfg_write(reg_addr(tile, 2), cfg_data_t'(n));
        cfg_write(reg_addr(tile, 1), cfg_data_t'((start << 1) | 1));
        cfg_write(reg_addr(tile, 0), 16'h0001);
        expect_read(reg_addr(tile, 0), 16'h0001, "dma_on set");
        stream_words(n);
        wait_irq(tile, base[tile] + 1);
        for (int i = 0; i < n; i++) begin
            expect_read(bank_addr(tile, start + i), sent[i],
                        $sformatf("tile %0d bank word %0d", tile, (start + i) & 'hff));
        end
        expect_read(reg_addr(tile, 1), cfg_data_t'(start << 1), "header 0 valid cleared");
        check_irq_counts(base, tile, 1);
        cfg_write(reg_addr(tile, 0), '0);
    endtask

    // two headers from one burst, then a valid header with dma off
    task automatic test_queue_and_gating(input int tile);
        int         start0;
        int         start1;
        int         n0;
        int         n1;
        int         base [NUM_TILES];
        data_word_t first [$];
        start0 = $urandom_range(60, 0);
        start1 = start0 + 100;
        n0     = $urandom_range(8, 3);
        n1     = $urandom_range(8, 3);
        base   = irq_seen;
        cfg_write(reg_addr(tile, 2), cfg_data_t'(n0));
        cfg_write(reg_addr(tile, 1), cfg_data_t'((start0 << 1) | 1));
        cfg_write(reg_addr(tile, 4), cfg_data_t'(n1));
        cfg_write(reg_addr(tile, 3), cfg_data_t'((start1 << 1) | 1));
        cfg_write(reg_addr(tile, 0), 16'h0001);
        expect_read(reg_addr(tile, 0), 16'h0001, "dma_on set");
        stream_words(n0 + n1);
        wait_irq(tile, base[tile] + 2);
        for (int i = 0; i < n0; i++) begin
            expect_read(bank_addr(tile, start0 + i), sent[i], $sformatf("header 0 word %0d", i));
            first.push_back(sent[i]);
        end
        for (int i = 0; i < n1; i++) begin
            expect_read(bank_addr(tile, start1 + i), sent[n0 + i],
                        $sformatf("header 1 word %0d", i));
        end
        expect_read(reg_addr(tile, 1), cfg_data_t'(start0 << 1), "header 0 retired");
        expect_read(reg_addr(tile, 3), cfg_data_t'(start1 << 1), "header 1 retired");
        check_irq_counts(base, tile, 2);
        // header 2 over the header 0 area, dma off
        cfg_write(reg_addr(tile, 0), '0);
        cfg_write(reg_addr(tile, 6), cfg_data_t'(n0));
        cfg_write(reg_addr(tile, 5), cfg_data_t'((start0 << 1) | 1));
        expect_read(reg_addr(tile, 5), cfg_data_t'((start0 << 1) | 1), "header 2 queued");
        stream_words(n0);
        for (int i = 0; i < n0; i++) begin
            expect_read(bank_addr(tile, start0 + i), first[i],
                        $sformatf("gated word %0d unchanged", i));
        end
        expect_read(reg_addr(tile, 5), cfg_data_t'((start0 << 1) | 1), "header 2 still valid");
        check_irq_counts(base, tile, 2);
    endtask

    initial begin
        int store_tile;
        int queue_tile;
        void'($urandom(32'hc28d_bbf6));
        errors       = 0;
        checks       = 0;
        timeouts     = 0;
        reset        = 1'b1;
        cfg_wr_en    = 1'b0;
        cfg_wr_addr  = '0;
        cfg_wr_data  = '0;
        cfg_rd_en    = 1'b0;
        cfg_rd_addr  = '0;
        stream_data  = '0;
        stream_valid = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        test_registers();
        test_isolation();
        // two different tiles, each starts at header 0
        store_tile = $urandom_range(NUM_TILES - 1, 0);
        queue_tile = (store_tile + $urandom_range(NUM_TILES - 1, 1)) % NUM_TILES;
        test_store(store_tile);
        test_queue_and_gating(queue_tile);

        $display("summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* glb_top.sv */
// global buffer, a row of NUM_TILES tiles
// host config enters at the east end (highest tile id)
// interrupt_pulse leaves the east end, one bit per tile
// stream input is broadcast to every tile
module glb_top
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       cfg_wr_en,
    input  cfg_addr_t  cfg_wr_addr,
    input  cfg_data_t  cfg_wr_data,
    input  logic       cfg_rd_en,
    input  cfg_addr_t  cfg_rd_addr,
    output cfg_data_t  cfg_rd_data,
    output logic       cfg_rd_data_valid,
    input  data_word_t stream_data,
    input  logic       stream_valid,
    output irq_vec_t   interrupt_pulse
);

    // index i+1 is the east side of tile i, index 0 the open west end
    logic      wr_en_c   [NUM_TILES+1];
    cfg_addr_t wr_addr_c [NUM_TILES+1];
    cfg_data_t wr_data_c [NUM_TILES+1];
    logic      rd_en_c   [NUM_TILES+1];
    cfg_addr_t rd_addr_c [NUM_TILES+1];
    cfg_data_t rd_data_c [NUM_TILES+1];
    logic      rd_vld_c  [NUM_TILES+1];
    irq_vec_t  irq_c     [NUM_TILES+1];

    assign wr_en_c[NUM_TILES]   = cfg_wr_en;
    assign wr_addr_c[NUM_TILES] = cfg_wr_addr;
    assign wr_data_c[NUM_TILES] = cfg_wr_data;
    assign rd_en_c[NUM_TILES]   = cfg_rd_en;
    assign rd_addr_c[NUM_TILES] = cfg_rd_addr;
    assign cfg_rd_data          = rd_data_c[NUM_TILES];
    assign cfg_rd_data_valid    = rd_vld_c[NUM_TILES];

    // nothing returns from west of tile 0
    assign rd_data_c[0] = '0;
    assign rd_vld_c[0]  = 1'b0;
    assign irq_c[0]     = '0;
    assign interrupt_pulse = irq_c[NUM_TILES];

    for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
        glb_tile #(.tile_id(tile_id_t'(i))) u_tile (
            .clk, .reset,
            .cfg_wr_en(wr_en_c[i+1]), .cfg_wr_addr(wr_addr_c[i+1]),
            .cfg_wr_data(wr_data_c[i+1]), .cfg_rd_en(rd_en_c[i+1]),
            .cfg_rd_addr(rd_addr_c[i+1]), .cfg_rd_data(rd_data_c[i+1]),
            .cfg_rd_data_valid(rd_vld_c[i+1]),
            .wst_wr_en(wr_en_c[i]), .wst_wr_addr(wr_addr_c[i]), .wst_wr_data(wr_data_c[i]),
            .wst_rd_en(rd_en_c[i]), .wst_rd_addr(rd_addr_c[i]),
            .wst_rd_data(rd_data_c[i]), .wst_rd_data_valid(rd_vld_c[i]),
            .stream_data, .stream_valid,
            .irq_wsti(irq_c[i]), .irq_esto(irq_c[i+1])
        );
    end

endmodule

/* glb_tile.sv */
// one global buffer tile: config node, store dma and bank
// tile_id fixes the position in the chain and the interrupt bit
// interrupt vector is registered once per tile on its way east
module glb_tile
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;
#(
    parameter tile_id_t tile_id = '0
) (
    input  logic       clk,
    input  logic       reset,
    // east config side
    input  logic       cfg_wr_en,
    input  cfg_addr_t  cfg_wr_addr,
    input  cfg_data_t  cfg_wr_data,
    input  logic       cfg_rd_en,
    input  cfg_addr_t  cfg_rd_addr,
    output cfg_data_t  cfg_rd_data,
    output logic       cfg_rd_data_valid,
    // west config side
    output logic       wst_wr_en,
    output cfg_addr_t  wst_wr_addr,
    output cfg_data_t  wst_wr_data,
    output logic       wst_rd_en,
    output cfg_addr_t  wst_rd_addr,
    input  cfg_data_t  wst_rd_data,
    input  logic       wst_rd_data_valid,
    // shared stream
    input  data_word_t stream_data,
    input  logic       stream_valid,
    // interrupt chain
    input  irq_vec_t   irq_wsti,
    output irq_vec_t   irq_esto
);

    logic                   dma_on;
    logic [QUEUE_DEPTH-1:0] hdr_valid;
    bank_addr_t             hdr_start_addr [QUEUE_DEPTH];
    num_words_t             hdr_num_words [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] hdr_clear;
    logic                   bank_rd_en;
    bank_addr_t             bank_rd_addr;
    data_word_t             bank_rd_data;
    logic                   bank_wr_en;
    bank_addr_t             bank_wr_addr;
    data_word_t             bank_wr_data;
    logic                   dma_done;
    irq_vec_t               tile_bit;
    irq_vec_t               irq_merged;

    glb_cfg_node #(.tile_id(tile_id)) u_cfg_node (.*);

    glb_store_dma u_store_dma (
        .clk, .reset, .dma_on, .hdr_valid, .hdr_start_addr, .hdr_num_words,
        .stream_data, .stream_valid, .hdr_clear, .bank_wr_en, .bank_wr_addr,
        .bank_wr_data, .done(dma_done)
    );

    glb_bank u_bank (
        .clk, .wr_en(bank_wr_en), .wr_addr(bank_wr_addr), .wr_data(bank_wr_data),
        .rd_en(bank_rd_en), .rd_addr(bank_rd_addr), .rd_data(bank_rd_data)
    );

    // replace our bit of the incoming vector with the done pulse
    assign tile_bit   = irq_vec_t'(1) << tile_id;
    assign irq_merged = (irq_wsti & ~tile_bit) | (dma_done ? tile_bit : '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            irq_esto <= '0;
        end else begin
            irq_esto <= irq_merged;
        end
    end

endmodule

/* glb_cfg_node.sv */
// per-tile configuration node
// accesses for other tiles go west one cycle later
// register reads answer in 1 cycle, bank reads in 2
// host keeps one read in flight, there is no back-pressure
// bank region is read-only from the host, writes there are dropped
module glb_cfg_node
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;
#(
    parameter tile_id_t tile_id = '0
) (
    input  logic                   clk,
    input  logic                   reset,
    // east side
    input  logic                   cfg_wr_en,
    input  cfg_addr_t              cfg_wr_addr,
    input  cfg_data_t              cfg_wr_data,
    input  logic                   cfg_rd_en,
    input  cfg_addr_t              cfg_rd_addr,
    output cfg_data_t              cfg_rd_data,
    output logic                   cfg_rd_data_valid,
    // west side
    output logic                   wst_wr_en,
    output cfg_addr_t              wst_wr_addr,
    output cfg_data_t              wst_wr_data,
    output logic                   wst_rd_en,
    output cfg_addr_t              wst_rd_addr,
    input  cfg_data_t              wst_rd_data,
    input  logic                   wst_rd_data_valid,
    // store dma control
    output logic                   dma_on,
    output logic [QUEUE_DEPTH-1:0] hdr_valid,
    output bank_addr_t             hdr_start_addr [QUEUE_DEPTH],
    output num_words_t             hdr_num_words [QUEUE_DEPTH],
    input  logic [QUEUE_DEPTH-1:0] hdr_clear,
    // bank read port
    output logic                   bank_rd_en,
    output bank_addr_t             bank_rd_addr,
    input  data_word_t             bank_rd_data
);

    logic                       wr_match;
    logic                       rd_match;
    reg_idx_t                   wr_idx;
    reg_idx_t                   rd_idx;
    reg_idx_t                   wr_off;
    reg_idx_t                   rd_off;
    logic [QUEUE_PTR_WIDTH-1:0] wr_q;
    logic [QUEUE_PTR_WIDTH-1:0] rd_q;
    logic                       wr_hdr_hit;
    logic                       rd_hdr_hit;
    logic                       local_wr;
    logic                       reg_rd;
    logic                       bank_rd_pending;
    cfg_data_t                  reg_rd_data;
    logic                       local_rd_valid;
    cfg_data_t                  local_rd_data;

    // tile field compare
    assign wr_match = (cfg_wr_addr[CFG_TILE_LSB +: TILE_ID_WIDTH] == tile_id);
    assign rd_match = (cfg_rd_addr[CFG_TILE_LSB +: TILE_ID_WIDTH] == tile_id);

    // register index and header slot
    assign wr_idx     = cfg_wr_addr[CFG_REG_IDX_WIDTH-1:0];
    assign rd_idx     = cfg_rd_addr[CFG_REG_IDX_WIDTH-1:0];
    assign wr_off     = wr_idx - REG_HDR_BASE;
    assign rd_off     = rd_idx - REG_HDR_BASE;
    assign wr_q       = wr_off[QUEUE_PTR_WIDTH:1];
    assign rd_q       = rd_off[QUEUE_PTR_WIDTH:1];
    assign wr_hdr_hit = (wr_idx >= REG_HDR_BASE) && (wr_off < reg_idx_t'(2 * QUEUE_DEPTH));
    assign rd_hdr_hit = (rd_idx >= REG_HDR_BASE) && (rd_off < reg_idx_t'(2 * QUEUE_DEPTH));

    assign local_wr = cfg_wr_en && wr_match && !cfg_wr_addr[CFG_BANK_SEL_BIT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dma_on    <= 1'b0;
            hdr_valid <= '0;
            for (int q = 0; q < QUEUE_DEPTH; q++) begin
                hdr_start_addr[q] <= '0;
                hdr_num_words[q]  <= '0;
            end
        end else begin
            // retired by the dma, a host write below overrides
            hdr_valid <= hdr_valid & ~hdr_clear;
            if (local_wr) begin
                if (wr_idx == REG_DMA_CTRL) begin
                    dma_on <= cfg_wr_data[0];
                end else if (wr_hdr_hit) begin
                    if (!wr_off[0]) begin
                        {hdr_start_addr[wr_q], hdr_valid[wr_q]} <= cfg_wr_data[BANK_ADDR_WIDTH:0];
                    end else begin
                        hdr_num_words[wr_q] <= cfg_wr_data[MAX_NUM_WORDS_WIDTH-1:0];
                    end
                end
            end
        end
    end

    // register read mux
    always_comb begin
        reg_rd_data = '0;
        if (rd_idx == REG_DMA_CTRL) begin
            reg_rd_data[0] = dma_on;
        end else if (rd_hdr_hit) begin
            if (!rd_off[0]) begin
                reg_rd_data[BANK_ADDR_WIDTH:0] = {hdr_start_addr[rd_q], hdr_valid[rd_q]};
            end else begin
                reg_rd_data[MAX_NUM_WORDS_WIDTH-1:0] = hdr_num_words[rd_q];
            end
        end
    end

    // local reads, bank data shows up one cycle after the strobe
    assign reg_rd       = cfg_rd_en && rd_match && !cfg_rd_addr[CFG_BANK_SEL_BIT];
    assign bank_rd_en   = cfg_rd_en && rd_match && cfg_rd_addr[CFG_BANK_SEL_BIT];
    assign bank_rd_addr = cfg_rd_addr[BANK_ADDR_WIDTH-1:0];

    assign local_rd_valid = reg_rd || bank_rd_pending;
    assign local_rd_data  = bank_rd_pending ? bank_rd_data : reg_rd_data;

    // strobes toward the west and back east
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wst_wr_en         <= 1'b0;
            wst_rd_en         <= 1'b0;
            bank_rd_pending   <= 1'b0;
            cfg_rd_data_valid <= 1'b0;
        end else begin
            wst_wr_en         <= cfg_wr_en && !wr_match;
            wst_rd_en         <= cfg_rd_en && !rd_match;
            bank_rd_pending   <= bank_rd_en;
            cfg_rd_data_valid <= local_rd_valid || wst_rd_data_valid;
        end
    end

    // payload follows its strobe
    always_ff @(posedge clk) begin
        if (cfg_wr_en) begin
            wst_wr_addr <= cfg_wr_addr;
            wst_wr_data <= cfg_wr_data;
        end
        if (cfg_rd_en) begin
            wst_rd_addr <= cfg_rd_addr;
        end
        if (local_rd_valid) begin
            cfg_rd_data <= local_rd_data;
        end else if (wst_rd_data_valid) begin
            cfg_rd_data <= wst_rd_data;
        end
    end

    // only one read in flight along the whole chain
    a_one_rd_response: assert property (@(posedge clk) disable iff (reset)
        !(local_rd_valid && wst_rd_data_valid));

    // our own writes never leak west
    a_no_own_fwd_wr: assert property (@(posedge clk) disable iff (reset)
        wst_wr_en |-> (wst_wr_addr[CFG_TILE_LSB +: TILE_ID_WIDTH] != tile_id));

endmodule

/* glb_store_dma.sv */
// store dma, streams words into the bank along the header queue
// a word is taken only while dma_on is set and the current header is valid
// words arriving otherwise are dropped
// done pulses one cycle after the last word, or at once for an empty header
module glb_store_dma
    import glb_param_pkg::*;
    import glb_cfg_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   dma_on,
    input  logic [QUEUE_DEPTH-1:0] hdr_valid,
    input  bank_addr_t             hdr_start_addr [QUEUE_DEPTH],
    input  num_words_t             hdr_num_words [QUEUE_DEPTH],
    input  data_word_t             stream_data,
    input  logic                   stream_valid,
    output logic [QUEUE_DEPTH-1:0] hdr_clear,
    output logic                   bank_wr_en,
    output bank_addr_t             bank_wr_addr,
    output data_word_t             bank_wr_data,
    output logic                   done
);

    dma_state_t                 state;
    logic [QUEUE_PTR_WIDTH-1:0] hdr_ptr;
    num_words_t                 word_cnt;
    num_words_t                 cur_len;
    logic                       cur_ready;
    logic                       empty_hdr;
    logic                       take;
    logic                       last_word;
    logic                       finish;

    // current header view
    assign cur_len   = hdr_num_words[hdr_ptr];
    assign cur_ready = dma_on && hdr_valid[hdr_ptr];

    // zero-length header, only seen before any word was taken
    assign empty_hdr = cur_ready && (state == DMA_IDLE) && (cur_len == '0);

    assign take      = cur_ready && stream_valid && (cur_len != '0);
    assign last_word = take && (num_words_t'(word_cnt + 1'b1) == cur_len);
    assign finish    = empty_hdr || last_word;

    // one-hot retire strobe into the config node
    assign hdr_clear = {{(QUEUE_DEPTH-1){1'b0}}, finish} << hdr_ptr;

    // write in the same cycle the word is taken
    assign bank_wr_en   = take;
    assign bank_wr_addr = hdr_start_addr[hdr_ptr] + word_cnt[BANK_ADDR_WIDTH-1:0];
    assign bank_wr_data = stream_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= DMA_IDLE;
            hdr_ptr  <= '0;
            word_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= finish;
            case (state)
                DMA_IDLE: begin
                    // word_cnt is zero here
                    if (finish) begin
                        hdr_ptr <= hdr_ptr + 1'b1;
                    end else if (take) begin
                        state    <= DMA_RUN;
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                DMA_RUN: begin
                    if (finish) begin
                        // next header, wraps at queue depth
                        state    <= DMA_IDLE;
                        word_cnt <= '0;
                        hdr_ptr  <= hdr_ptr + 1'b1;
                    end else if (take) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= DMA_IDLE;
                end
            endcase
        end
    end

    // bank writes never run past the end of the live header
    a_wr_in_hdr: assert property (@(posedge clk) disable iff (reset)
        bank_wr_en |-> (word_cnt < cur_len));

endmodule

/* glb_bank.sv */
// one sram bank per tile, 256 words
// write port from the store dma, read port from the config node
// read data is registered, valid the cycle after rd_en
// contents are undefined until written
module glb_bank
    import glb_param_pkg::*;
(
    input  logic       clk,
    // dma side
    input  logic       wr_en,
    input  bank_addr_t wr_addr,
    input  data_word_t wr_data,
    // host side
    input  logic       rd_en,
    input  bank_addr_t rd_addr,
    output data_word_t rd_data
);

    data_word_t mem [BANK_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // synchronous read, holds last value when idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* glb_cfg_pkg.sv */
// configuration address map of the global buffer
// addr[15:12] tile id, addr[11] picks bank (1) or registers (0)
// bank word in addr[7:0], register index in addr[4:0]
// unmapped register indices read zero and drop writes
package glb_cfg_pkg;

    localparam int CFG_ADDR_WIDTH = 16;
    localparam int CFG_DATA_WIDTH = 16;

    // address fields
    localparam int CFG_TILE_LSB      = 12;
    localparam int CFG_BANK_SEL_BIT  = 11;
    localparam int CFG_REG_IDX_WIDTH = 5;

    typedef logic [CFG_ADDR_WIDTH-1:0]    cfg_addr_t;
    typedef logic [CFG_DATA_WIDTH-1:0]    cfg_data_t;
    typedef logic [CFG_REG_IDX_WIDTH-1:0] reg_idx_t;

    // bit 0 is dma_on
    localparam reg_idx_t REG_DMA_CTRL = 5'd0;

    // header q at REG_HDR_BASE + 2q (start_addr, valid)
    // and REG_HDR_BASE + 2q + 1 (num_words)
    localparam reg_idx_t REG_HDR_BASE = 5'd1;

    // store dma sequencing
    typedef enum logic {
        DMA_IDLE,
        DMA_RUN
    } dma_state_t;

endpackage

/* glb_param_pkg.sv */
// sizes of the global buffer data path, stream and bank
// one bank per tile, one stream input shared by all tiles
// queue depth must be a power of two, the header pointer wraps freely
// word counts above the bank size wrap inside the bank
package glb_param_pkg;

    // chain length and tile id field
    localparam int NUM_TILES     = 4;
    localparam int TILE_ID_WIDTH = 4;

    // stream word from the array
    localparam int CGRA_DATA_WIDTH = 16;

    // bank geometry, 256 words
    localparam int BANK_ADDR_WIDTH = 8;
    localparam int BANK_DEPTH      = 1 << BANK_ADDR_WIDTH;

    // store dma header queue
    localparam int MAX_NUM_WORDS_WIDTH = 9;
    localparam int QUEUE_DEPTH         = 4;
    localparam int QUEUE_PTR_WIDTH     = $clog2(QUEUE_DEPTH);

    // one stream or bank word
    typedef logic [CGRA_DATA_WIDTH-1:0] data_word_t;

    // word address inside a bank
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // words per header
    typedef logic [MAX_NUM_WORDS_WIDTH-1:0] num_words_t;

    // position of a tile in the chain
    typedef logic [TILE_ID_WIDTH-1:0] tile_id_t;

    // one done bit per tile
    typedef logic [NUM_TILES-1:0] irq_vec_t;

endpackage
